// ==== design/lv_pkg.sv ====
/* shared types and sizes for the lv die control core
   state codes 0..10 are fixed and codes 11..15 are unused */
package lv_pkg;

	//============================================================
	// sizes
	//============================================================
	localparam int STATE_W     = 4;          // control state code width
	localparam int EFUSE_WORDS = 4;          // trim words in the efuse macro
	localparam int EFUSE_AW    = 2;          // efuse word address width
	localparam int EFUSE_DW    = 9;          // data byte plus odd parity bit
	localparam int TRIM_BW     = 8;          // trim byte width

	//============================================================
	// control states
	//============================================================
	typedef enum logic [STATE_W-1:0] {
		POWER_DOWN_ST   = 4'd0,
		WAIT_ST         = 4'd1,
		TEST_ST         = 4'd2,
		NORMAL_ST       = 4'd3,
		FAILSAFE_ST     = 4'd4,
		OW_COMM_ERR_ST  = 4'd5,
		OW_WDG_FAULT_ST = 4'd6,
		FAULT_ST        = 4'd7,
		CFG_ST          = 4'd8,
		RST_ST          = 4'd9,
		BIST_ST         = 4'd10
	} lv_state_e;

	//============================================================
	// error strobes, fault classes, commands, enables
	//============================================================
	typedef struct packed {
		logic ow_com;       // one-wire protocol or crc error
		logic ow_wdg;       // one-wire lost ack
		logic spi;          // spi protocol or crc error
		logic crc_wdg;      // config register crc scan mismatch
		logic lv_pwm_dt;    // pwm dead time
		logic lv_pwm_mm;    // pwm mismatch
		logic lv_vsup_uv;
		logic lv_vsup_ov;
		logic hv_vcc_uv;
		logic hv_vcc_ov;
		logic hv_ot;        // hv over temperature
		logic hv_oc;        // hv over current
		logic hv_desat;
		logic hv_scp;       // hv short circuit
		logic fsafe_pin;    // failsafe request
	} lv_err_t;

	typedef struct packed {
		logic severe;       // hv power stage faults
		logic supply;       // supply, pwm, crc, spi and failsafe pin
		logic ow_wdg;
		logic ow_com;
	} lv_fault_cls_t;

	typedef struct packed {
		logic power_on;
		logic test_mode;
		logic normal_en;
		logic cfg_en;
		logic bist_en;
		logic sft_rst;      // software reset request
	} lv_cmd_t;

	typedef struct packed {
		logic pwm;
		logic crc_wdg;
		logic ow_wdg;
		logic spi;
		logic bist;
		logic cfg;
		logic ow_comm;
		logic fsafe;        // drive the hv side into failsafe
	} lv_ctrl_t;

	typedef struct packed {
		logic [EFUSE_WORDS-1:0][TRIM_BW-1:0] data;  // word 0 in the low byte
		logic                                ok;    // all words passed parity
	} lv_trim_t;

endpackage

// ==== design/lv_fault_collect.sv ====
/* sticky error latch with class flags, cleared only by i_clr_faults
   i_fsenb_n is asynchronous and level sensitive, so it sees two extra cycles of sync delay */
`timescale 1ns/1ps

module lv_fault_collect (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  lv_pkg::lv_err_t       i_err,         // single cycle error strobes
	input  logic                  i_fsenb_n,     // failsafe pin, low active
	input  logic                  i_clr_faults,  // empties all sticky bits
	output lv_pkg::lv_fault_cls_t o_cls
);

	//============================================================
	// failsafe pin synchronizer
	//============================================================
	logic [1:0]            fsenb_sync;
	logic                  fsafe_lvl;
	lv_pkg::lv_err_t       err_in;
	lv_pkg::lv_err_t       sticky;
	lv_pkg::lv_fault_cls_t cls_d;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fsenb_sync <= 2'b11;                   // pin released
		end else begin
			fsenb_sync <= {fsenb_sync[0], i_fsenb_n};
		end
	end

	assign fsafe_lvl = ~fsenb_sync[1];

	always_comb begin
		err_in           = i_err;
		err_in.fsafe_pin = i_err.fsafe_pin | fsafe_lvl;   // pin or strobe
	end

	//============================================================
	// sticky bits and class flags
	//============================================================
	// a new error wins over a clear in the same cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sticky <= '0;
		end else if (i_clr_faults) begin
			sticky <= err_in;
		end else begin
			sticky <= sticky | err_in;
		end
	end

	always_comb begin
		cls_d.severe = sticky.hv_ot | sticky.hv_oc | sticky.hv_desat | sticky.hv_scp;
		cls_d.supply = sticky.lv_vsup_uv | sticky.lv_vsup_ov
		             | sticky.hv_vcc_uv  | sticky.hv_vcc_ov
		             | sticky.lv_pwm_dt  | sticky.lv_pwm_mm
		             | sticky.crc_wdg    | sticky.spi
		             | sticky.fsafe_pin;
		cls_d.ow_wdg = sticky.ow_wdg;
		cls_d.ow_com = sticky.ow_com;
	end

	// The classes drop together with the sticky bits, so the FSM
	// never sees a stale class once it is back in WAIT_ST.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cls <= '0;
		end else if (i_clr_faults) begin
			o_cls <= '0;
		end else begin
			o_cls <= cls_d;
		end
	end

	//============================================================
	// checks
	//============================================================
	// classes stay low through the sticky stage after a clean clear
	a_clr_empties: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_clr_faults && (err_in == '0)) |=> (o_cls == '0) [*2]
	);

endmodule

// ==== design/lv_efuse_loader.sv ====
/* reads EFUSE_WORDS trim words after each start, one read outstanding at a time
   i_efuse_vld at start skips the reads and keeps the stored bytes */
`timescale 1ns/1ps

module lv_efuse_loader (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic                          i_load_start,  // restarts a load at any time
	input  logic                          i_efuse_vld,   // trim already valid
	output logic                          o_rd_stb,
	output logic [lv_pkg::EFUSE_AW-1:0]   o_rd_addr,
	input  logic                          i_rd_vld,
	input  logic [lv_pkg::EFUSE_DW-1:0]   i_rd_data,     // parity in the msb
	output logic                          o_load_done,   // held until next start
	output lv_pkg::lv_trim_t              o_trim
);

	logic                                                busy;
	logic                                                skip;
	logic [lv_pkg::EFUSE_AW-1:0]                         word_idx;
	logic                                                word_ok;
	logic                                                last_word;
	logic                                                trim_ok;
	logic [lv_pkg::EFUSE_WORDS-1:0][lv_pkg::TRIM_BW-1:0] trim_data;

	assign word_ok   = ^i_rd_data;                     // odd parity over all 9 bits
	assign last_word = (word_idx == lv_pkg::EFUSE_AW'(lv_pkg::EFUSE_WORDS - 1));
	assign o_rd_addr = word_idx;

	//============================================================
	// read sequencer
	//============================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy        <= 1'b0;
			skip        <= 1'b0;
			word_idx    <= '0;
			o_rd_stb    <= 1'b0;
			o_load_done <= 1'b0;
			trim_ok     <= 1'b0;
		end else begin
			o_rd_stb <= 1'b0;
			skip     <= 1'b0;
			if (i_load_start) begin
				o_load_done <= 1'b0;
				word_idx    <= '0;
				trim_ok     <= 1'b1;
				busy        <= ~i_efuse_vld;
				skip        <= i_efuse_vld;
				o_rd_stb    <= ~i_efuse_vld;       // first read right away
			end else if (skip) begin
				o_load_done <= 1'b1;
			end else if (busy && i_rd_vld) begin
				trim_ok <= trim_ok & word_ok;
				if (last_word) begin
					busy        <= 1'b0;
					o_load_done <= 1'b1;
				end else begin
					word_idx <= word_idx + 1'b1;
					o_rd_stb <= 1'b1;              // next word after the answer
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_load_start && busy && i_rd_vld) begin
			trim_data[word_idx] <= i_rd_data[lv_pkg::TRIM_BW-1:0];
		end
	end

	assign o_trim.data = trim_data;
	assign o_trim.ok   = trim_ok;

	// each strobe waits for the macro answer of the one before
	a_one_outstanding: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_rd_stb |=> (!o_rd_stb) until i_rd_vld
	);

endmodule

// ==== design/lv_ctrl_fsm.sv ====
/* main state machine of the lv die, enables and o_int_n are registered from the state
   fault states are left only for a worse fault, sft_rst or power_on low */
`timescale 1ns/1ps

module lv_ctrl_fsm (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  lv_pkg::lv_cmd_t       i_cmd,         // command levels
	input  lv_pkg::lv_fault_cls_t i_cls,         // registered sticky classes
	input  logic                  i_load_done,
	output logic                  o_load_start,
	output logic                  o_clr_faults,
	output lv_pkg::lv_ctrl_t      o_ctrl,
	output logic                  o_int_n,       // low while in a fault state
	output lv_pkg::lv_state_e     o_state
);

	lv_pkg::lv_state_e cur_st;
	lv_pkg::lv_state_e nxt_st;
	logic [2:0]        cur_rank;
	lv_pkg::lv_ctrl_t  ctrl_d;
	logic              int_n_d;

	//============================================================
	// state register
	//============================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cur_st <= lv_pkg::POWER_DOWN_ST;
		end else begin
			cur_st <= nxt_st;
		end
	end

	// fault severity of the current state, 0 outside the fault states
	always_comb begin
		case (cur_st)
			lv_pkg::FAULT_ST:        cur_rank = 3'd4;
			lv_pkg::FAILSAFE_ST:     cur_rank = 3'd3;
			lv_pkg::OW_WDG_FAULT_ST: cur_rank = 3'd2;
			lv_pkg::OW_COMM_ERR_ST:  cur_rank = 3'd1;
			default:                 cur_rank = 3'd0;
		endcase
	end

	//============================================================
	// next state
	//============================================================
	always_comb begin
		nxt_st = cur_st;
		if (!i_cmd.power_on) begin
			nxt_st = lv_pkg::POWER_DOWN_ST;
		end else if (cur_st == lv_pkg::POWER_DOWN_ST || cur_st == lv_pkg::RST_ST) begin
			nxt_st = lv_pkg::WAIT_ST;
		end else if (i_cmd.sft_rst) begin
			nxt_st = lv_pkg::RST_ST;
		end else if (i_cls.severe) begin
			nxt_st = lv_pkg::FAULT_ST;
		end else if (i_cls.supply && cur_rank < 3'd3) begin
			nxt_st = lv_pkg::FAILSAFE_ST;
		end else if (i_cls.ow_wdg && cur_rank < 3'd2) begin
			nxt_st = lv_pkg::OW_WDG_FAULT_ST;
		end else if (i_cls.ow_com && cur_rank < 3'd1) begin
			nxt_st = lv_pkg::OW_COMM_ERR_ST;
		end else begin
			case (cur_st)
				lv_pkg::WAIT_ST: begin
					if (i_load_done) begin             // trim loaded first
						if (i_cmd.test_mode) begin
							nxt_st = lv_pkg::TEST_ST;
						end else if (i_cmd.cfg_en) begin
							nxt_st = lv_pkg::CFG_ST;
						end else if (i_cmd.normal_en) begin
							nxt_st = lv_pkg::NORMAL_ST;
						end
					end
				end
				lv_pkg::TEST_ST: begin
					if (!i_cmd.test_mode) begin
						nxt_st = lv_pkg::WAIT_ST;
					end
				end
				lv_pkg::CFG_ST: begin
					if (!i_cmd.cfg_en) begin
						nxt_st = lv_pkg::WAIT_ST;
					end
				end
				lv_pkg::NORMAL_ST: begin
					if (i_cmd.bist_en) begin
						nxt_st = lv_pkg::BIST_ST;
					end else if (i_cmd.cfg_en) begin
						nxt_st = lv_pkg::CFG_ST;
					end
				end
				lv_pkg::BIST_ST: begin
					if (!i_cmd.bist_en) begin
						nxt_st = lv_pkg::NORMAL_ST;
					end
				end
				lv_pkg::FAULT_ST, lv_pkg::FAILSAFE_ST,
				lv_pkg::OW_WDG_FAULT_ST, lv_pkg::OW_COMM_ERR_ST: begin
					nxt_st = cur_st;                   // latched until sft_rst
				end
				default: begin
					nxt_st = lv_pkg::POWER_DOWN_ST;    // unused codes
				end
			endcase
		end
	end

	// load starts on the same edge that enters WAIT_ST, so done is low there
	assign o_load_start = (cur_st == lv_pkg::POWER_DOWN_ST || cur_st == lv_pkg::RST_ST)
	                    && (nxt_st == lv_pkg::WAIT_ST);
	assign o_clr_faults = (cur_st == lv_pkg::RST_ST);
	assign o_state      = cur_st;

	//============================================================
	// output decode
	//============================================================
	always_comb begin
		ctrl_d  = '0;
		int_n_d = 1'b1;
		case (cur_st)
			lv_pkg::WAIT_ST: begin
				ctrl_d.spi     = 1'b1;
				ctrl_d.ow_comm = 1'b1;
			end
			lv_pkg::TEST_ST, lv_pkg::CFG_ST: begin
				ctrl_d.spi     = 1'b1;
				ctrl_d.ow_comm = 1'b1;
				ctrl_d.cfg     = 1'b1;
			end
			lv_pkg::NORMAL_ST: begin
				ctrl_d.pwm     = 1'b1;
				ctrl_d.crc_wdg = 1'b1;
				ctrl_d.ow_wdg  = 1'b1;
				ctrl_d.spi     = 1'b1;
				ctrl_d.ow_comm = 1'b1;
			end
			lv_pkg::BIST_ST: begin
				ctrl_d.spi     = 1'b1;
				ctrl_d.ow_comm = 1'b1;
				ctrl_d.bist    = 1'b1;
			end
			lv_pkg::FAULT_ST, lv_pkg::FAILSAFE_ST: begin
				ctrl_d.spi     = 1'b1;
				ctrl_d.ow_comm = 1'b1;
				ctrl_d.fsafe   = 1'b1;
				int_n_d        = 1'b0;
			end
			lv_pkg::OW_COMM_ERR_ST, lv_pkg::OW_WDG_FAULT_ST: begin
				ctrl_d.spi     = 1'b1;                 // one-wire link is down
				ctrl_d.fsafe   = 1'b1;
				int_n_d        = 1'b0;
			end
			default: begin
				ctrl_d  = '0;                          // power down and reset
				int_n_d = 1'b1;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ctrl  <= '0;
			o_int_n <= 1'b1;
		end else begin
			o_ctrl  <= ctrl_d;
			o_int_n <= int_n_d;
		end
	end

	// pwm must never run while the hv side is held in failsafe
	a_pwm_fsafe: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!(o_ctrl.pwm && o_ctrl.fsafe)
	);

endmodule

// ==== design/lv_core.sv ====
/* control core of the lv die, bus logic and the efuse macro sit outside
   all strobes are single cycle and nothing applies back-pressure */
`timescale 1ns/1ps

module lv_core (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  lv_pkg::lv_cmd_t             i_cmd,
	input  lv_pkg::lv_err_t             i_err,
	input  logic                        i_fsenb_n,     // failsafe pin, low active
	input  logic                        i_efuse_vld,
	output logic                        o_rd_stb,      // efuse macro read
	output logic [lv_pkg::EFUSE_AW-1:0] o_rd_addr,
	input  logic                        i_rd_vld,
	input  logic [lv_pkg::EFUSE_DW-1:0] i_rd_data,
	output lv_pkg::lv_trim_t            o_trim,
	output lv_pkg::lv_ctrl_t            o_ctrl,
	output logic                        o_int_n,
	output lv_pkg::lv_state_e           o_state
);

	lv_pkg::lv_fault_cls_t cls;
	logic                  clr_faults;
	logic                  load_start;
	logic                  load_done;

	//============================================================
	// blocks
	//============================================================
	lv_fault_collect u_fault_collect (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_err        (i_err),
		.i_fsenb_n    (i_fsenb_n),
		.i_clr_faults (clr_faults),
		.o_cls        (cls)
	);

	lv_efuse_loader u_efuse_loader (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_load_start (load_start),
		.i_efuse_vld  (i_efuse_vld),
		.o_rd_stb     (o_rd_stb),
		.o_rd_addr    (o_rd_addr),
		.i_rd_vld     (i_rd_vld),
		.i_rd_data    (i_rd_data),
		.o_load_done  (load_done),
		.o_trim       (o_trim)
	);

	lv_ctrl_fsm u_ctrl_fsm (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_cmd        (i_cmd),
		.i_cls        (cls),
		.i_load_done  (load_done),
		.o_load_start (load_start),
		.o_clr_faults (clr_faults),
		.o_ctrl       (o_ctrl),
		.o_int_n      (o_int_n),
		.o_state      (o_state)
	);

endmodule

// ==== test/tb_lv_core.sv ====
/* testbench for lv_core that runs from the project root on test/lv_core_vectors.txt
   the efuse model answers each read after exactly 2 cycles and the vectors rely on it */
`timescale 1ns/1ps

module tb_lv_core;

	typedef struct packed {
		logic [15:0]       cnt;
		lv_pkg::lv_cmd_t   cmd;
		lv_pkg::lv_err_t   err;
		logic              fsenb_n;
		logic              efuse_vld;
		logic [3:0]        bad_word;
		lv_pkg::lv_state_e exp_state;
		lv_pkg::lv_ctrl_t  exp_ctrl;
		logic              exp_int_n;
		logic [1:0]        check;
	} vec_t;

	logic                          clk;
	logic                          rst_n;
	lv_pkg::lv_cmd_t               cmd;
	lv_pkg::lv_err_t               err;
	logic                          fsenb_n;
	logic                          efuse_vld;
	logic                          rd_stb;
	logic [lv_pkg::EFUSE_AW-1:0]   rd_addr;
	logic                          rd_vld = 1'b0;
	logic [lv_pkg::EFUSE_DW-1:0]   rd_data = '0;
	lv_pkg::lv_trim_t              trim;
	lv_pkg::lv_ctrl_t              ctrl;
	logic                          int_n;
	lv_pkg::lv_state_e             state;

	logic [3:0]                    bad_word = 4'hf;
	logic                          stb_d1 = 1'b0;
	logic [lv_pkg::EFUSE_AW-1:0]   addr_d1 = '0;
	logic [lv_pkg::TRIM_BW-1:0]    trim_bytes [lv_pkg::EFUSE_WORDS];
	vec_t                          vecs [$];
	int                            total_cycles = 0;
	logic                          loaded = 1'b0;
	integer                        seed = 32'h1194_a459;

	lv_core i_dut (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_cmd       (cmd),
		.i_err       (err),
		.i_fsenb_n   (fsenb_n),
		.i_efuse_vld (efuse_vld),
		.o_rd_stb    (rd_stb),
		.o_rd_addr   (rd_addr),
		.i_rd_vld    (rd_vld),
		.i_rd_data   (rd_data),
		.o_trim      (trim),
		.o_ctrl      (ctrl),
		.o_int_n     (int_n),
		.o_state     (state)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;                  // 20 ns period
	end

	//============================================================
	// failure reporting and compare tasks
	//============================================================
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_state(input lv_pkg::lv_state_e exp_v, input lv_pkg::lv_state_e got_v);
		if (got_v !== exp_v)
			stop_on_error($sformatf("FAILED t=%0t o_state exp %0d got %0d", $time, exp_v, got_v));
	endtask

	task automatic check_ctrl(input lv_pkg::lv_ctrl_t exp_v, input lv_pkg::lv_ctrl_t got_v);
		if (got_v !== exp_v)
			stop_on_error($sformatf("FAILED t=%0t o_ctrl exp %h got %h", $time, exp_v, got_v));
	endtask

	task automatic check_int(input logic exp_v, input logic got_v);
		if (got_v !== exp_v)
			stop_on_error($sformatf("FAILED t=%0t o_int_n exp %b got %b", $time, exp_v, got_v));
	endtask

	task automatic check_trim(input lv_pkg::lv_trim_t exp_v, input lv_pkg::lv_trim_t got_v);
		if (got_v !== exp_v)
			stop_on_error($sformatf("FAILED t=%0t o_trim exp %h got %h", $time, exp_v, got_v));
	endtask

	//============================================================
	// efuse macro model
	//============================================================
	// odd parity in the msb and one word may be broken on purpose
	function automatic logic [lv_pkg::EFUSE_DW-1:0] efuse_word(
		input logic [lv_pkg::EFUSE_AW-1:0] addr
	);
		logic [lv_pkg::TRIM_BW-1:0] b;
		logic                       par;
		b   = trim_bytes[addr];
		par = ~^b;
		if (bad_word == {2'b00, addr})
			par = ~par;
		return {par, b};
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			stb_d1 <= 1'b0;
			rd_vld <= 1'b0;
		end else begin
			if (rd_stb && efuse_vld)
				stop_on_error("efuse read issued although trim was marked valid");
			stb_d1  <= rd_stb;
			addr_d1 <= rd_addr;
			rd_vld  <= stb_d1;                   // answer 2 cycles after the strobe
			rd_data <= efuse_word(addr_d1);
		end
	end

	//============================================================
	// vector reader and stimulus
	//============================================================
	task automatic read_vectors();
		int    fd;
		int    n;
		int    f_cnt, f_cmd, f_err, f_fs, f_vld, f_bad, f_st, f_ctrl, f_int, f_chk;
		string line;
		vec_t  v;
		fd = $fopen("test/lv_core_vectors.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open test/lv_core_vectors.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %d", f_cnt, f_cmd, f_err, f_fs,
			            f_vld, f_bad, f_st, f_ctrl, f_int, f_chk);
			if (n != 10)
				stop_on_error($sformatf("malformed vector line: %s", line));
			v.cnt       = f_cnt[15:0];
			v.cmd       = f_cmd[5:0];
			v.err       = f_err[14:0];
			v.fsenb_n   = f_fs[0];
			v.efuse_vld = f_vld[0];
			v.bad_word  = f_bad[3:0];
			v.exp_state = lv_pkg::lv_state_e'(f_st[3:0]);
			v.exp_ctrl  = f_ctrl[7:0];
			v.exp_int_n = f_int[0];
			v.check     = f_chk[1:0];
			vecs.push_back(v);
			total_cycles += f_cnt;
		end
		$fclose(fd);
		if (vecs.size() == 0)
			stop_on_error("vector file holds no steps");
	endtask

	initial begin
		lv_pkg::lv_trim_t exp_trim;
		logic [31:0]      r;
		rst_n     = 1'b0;
		cmd       = '0;
		err       = '0;
		fsenb_n   = 1'b1;
		efuse_vld = 1'b0;
		for (int w = 0; w < lv_pkg::EFUSE_WORDS; w++) begin
			r             = $random(seed);
			trim_bytes[w] = r[7:0];
		end
		read_vectors();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		foreach (vecs[i]) begin
			for (int c = 0; c < int'(vecs[i].cnt); c++) begin
				@(posedge clk);
				cmd       <= vecs[i].cmd;
				err       <= vecs[i].err;
				fsenb_n   <= vecs[i].fsenb_n;
				efuse_vld <= vecs[i].efuse_vld;
				bad_word  <= vecs[i].bad_word;
			end
			@(negedge clk);                      // outputs settled
			if (vecs[i].check != 2'd0) begin
				check_state(vecs[i].exp_state, state);
				check_ctrl(vecs[i].exp_ctrl, ctrl);
				check_int(vecs[i].exp_int_n, int_n);
			end
			if (vecs[i].check >= 2'd2) begin
				for (int w = 0; w < lv_pkg::EFUSE_WORDS; w++)
					exp_trim.data[w] = trim_bytes[w];
				exp_trim.ok = (vecs[i].check == 2'd2);
				check_trim(exp_trim, trim);
			end
		end
		$display("PASS: all tests");
		$finish;
	end

	//============================================================
	// watchdog
	//============================================================
	initial begin
		wait (loaded);
		#((total_cycles + 4 + 100) * 20);         // vector cycles plus reset and margin
		$display("timeout: the vector run did not complete in time");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== lv_core.f ====
design/lv_pkg.sv
design/lv_fault_collect.sv
design/lv_efuse_loader.sv
design/lv_ctrl_fsm.sv
design/lv_core.sv
test/tb_lv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lv_core testbench with Verilator
# the exit status is the simulator's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_lv_core \
	--Mdir obj_dir \
	-o sim_lv_core \
	-f lv_core.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

if [ ! -x obj_dir/sim_lv_core ]; then
	echo "simulation binary missing after build"
	exit 1
fi

./obj_dir/sim_lv_core
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// ==== test/lv_core_vectors.txt ====
# lv_core stimulus, one line per step, each step lasts count clock cycles
# cols: count cmd err fsenb_n efuse_vld bad_word exp_state exp_ctrl exp_int_n check
# count and check are decimal, the other columns are hex
# cmd bits: power_on test_mode normal_en cfg_en bist_en sft_rst (msb first)
# ctrl bits: pwm crc_wdg ow_wdg spi bist cfg ow_comm fsafe (msb first)
# bad_word selects the efuse word with broken parity, f for none
# check: 0 none, 1 state ctrl int_n, 2 also trim with ok=1, 3 also trim with ok=0
# outputs are compared at the falling edge after the last cycle of a step
# efuse model answers 2 cycles after each read strobe
# power-up with efuse reads
3 00 0000 1 0 f 0 00 1 1
3 28 0000 1 0 f 1 12 1 1
13 28 0000 1 0 f 3 f2 1 2
# command paths
3 2a 0000 1 0 f a 1a 1 1
3 28 0000 1 0 f 3 f2 1 1
3 2c 0000 1 0 f 8 16 1 1
3 20 0000 1 0 f 1 12 1 1
3 30 0000 1 0 f 2 16 1 1
3 20 0000 1 0 f 1 12 1 1
3 28 0000 1 0 f 3 f2 1 1
# supply fault, then severe preempts, then ow_com is ignored
1 28 0100 1 0 f 0 00 1 0
4 28 0000 1 0 f 4 13 0 1
1 28 0008 1 0 f 0 00 1 0
4 28 0000 1 0 f 7 13 0 1
1 28 4000 1 0 f 0 00 1 0
4 28 0000 1 0 f 7 13 0 1
# soft reset, reload with a bad parity word
1 29 0000 1 0 2 0 00 1 0
1 28 0000 1 0 2 9 13 0 1
1 28 0000 1 0 2 1 00 1 1
14 28 0000 1 0 2 3 f2 1 3
# power off, power on with trim already valid
3 08 0000 1 0 f 0 00 1 1
3 28 0000 1 1 f 1 12 1 1
2 28 0000 1 1 f 3 f2 1 2
# ow_wdg fault and soft reset
1 28 2000 1 1 f 0 00 1 0
4 28 0000 1 1 f 6 11 0 1
1 29 0000 1 1 f 0 00 1 0
1 28 0000 1 1 f 9 11 0 1
4 28 0000 1 1 f 3 f2 1 2
# ow_com fault, failsafe pin overrides it, power off from a fault
1 28 4000 1 1 f 0 00 1 0
4 28 0000 1 1 f 5 11 0 1
7 28 0000 0 1 f 4 13 0 1
3 08 0000 0 1 f 0 00 1 1
4 28 0000 1 1 f 4 13 0 1
1 29 0000 1 1 f 0 00 1 0
5 28 0000 1 1 f 3 f2 1 2
